//--- Bender.yml
package:
  name: prog_loader

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/loader_pkg.sv
      - source/uart_rx.sv
      - source/rx_fifo.sv
      - source/word_loader.sv
      - source/prog_ram.sv
      - source/prog_loader.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/prog_loader_tb.sv

//--- bench/prog_loader_tb.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module prog_loader_tb;

  localparam int ROWS         = 6;
  localparam int EXTRA_WORDS  = 2;
  localparam int MODEL_WORDS  = 16;
  localparam int DONE_TIMEOUT = 50;

  // rst carries the clock and clk the active high reset
  logic                   rst;
  logic                   clk;
  logic                   uart_rx;
  logic                   rx_prog;
  logic [`ADDR_WIDTH-1:0] rd_addr;
  loader_pkg::word_t      rd_data;
  logic                   done;
  logic [`ADDR_WIDTH-1:0] word_count;
  logic                   rx_error;
  logic                   overrun;

  logic [31:0]       lcg_state;
  int                err_count;
  int                pass_count;
  int                fail_count;
  logic              tbl_prog  [ROWS];
  int                tbl_words [ROWS];
  logic              tbl_bad   [ROWS];
  logic              tbl_extra [ROWS];
  loader_pkg::word_t model_word  [MODEL_WORDS];
  logic              model_known [MODEL_WORDS];
  loader_pkg::word_t sent        [MODEL_WORDS];

  prog_loader u_prog_loader (
    .rst        (rst),
    .clk        (clk),
    .uart_rx    (uart_rx),
    .rx_prog    (rx_prog),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .done       (done),
    .word_count (word_count),
    .rx_error   (rx_error),
    .overrun    (overrun)
  );

  always #50 rst = ~rst;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // random word that is never the terminator and has two different bytes
  task automatic pick_word(output loader_pkg::word_t w);
    w = `LOAD_END_WORD;
    while (w == `LOAD_END_WORD || w[15:8] == w[7:0]) begin
      lcg_state = lcg_step(lcg_state);
      w = lcg_state[30:15];
    end
  endtask

  task automatic hold_bit();
    repeat (`CLKS_PER_BIT) @(posedge rst);
    #10;
  endtask

  // 8N1 frame plus one idle bit with the stop level chosen by the caller
  task automatic send_frame(input loader_pkg::byte_t data, input logic stop);
    uart_rx = 1'b0;
    hold_bit();
    for (int i = 0; i < 8; i++) begin
      uart_rx = data[i];
      hold_bit();
    end
    uart_rx = stop;
    hold_bit();
    uart_rx = 1'b1;
    hold_bit();
  endtask

  task automatic send_word(input loader_pkg::word_t w);
    send_frame(w[15:8], 1'b1);
    send_frame(w[7:0], 1'b1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic wait_done(input int row);
    int                      cycles;
    loader_pkg::load_state_e st;
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(posedge rst);
      #10;
      cycles++;
    end
    if (done !== 1'b1) begin
      st = u_prog_loader.u_word_loader.state;
      $display("row %0d: done did not rise within %0d cycles, loader still in %s",
               row, DONE_TIMEOUT, st.name());
      $display("SOME TESTS FAILED");
      $finish;
    end
  endtask

  // address applied now and data taken one cycle later
  task automatic read_word(input logic [`ADDR_WIDTH-1:0] addr,
                           output loader_pkg::word_t data);
    rd_addr = addr;
    @(posedge rst);
    #10;
    data = rd_data;
  endtask

  task automatic apply_reset(input logic prog);
    clk     = 1'b1;
    rx_prog = prog;
    uart_rx = 1'b1;
    rd_addr = '0;
    repeat (3) begin
      @(posedge rst);
      #10;
    end
    clk = 1'b0;
  endtask

  task automatic set_row(input int row, input logic prog, input int words,
                         input logic bad, input logic extra);
    tbl_prog[row]  = prog;
    tbl_words[row] = words;
    tbl_bad[row]   = bad;
    tbl_extra[row] = extra;
  endtask

  task automatic fill_table();
    // skip with bytes sent anyway
    set_row(0, 1'b0, 0, 1'b0, 1'b1);
    set_row(1, 1'b1, 5, 1'b0, 1'b1);
    set_row(2, 1'b1, 3, 1'b1, 1'b1);
    // terminator only
    set_row(3, 1'b1, 0, 1'b0, 1'b0);
    set_row(4, 1'b1, 6, 1'b0, 1'b1);
    set_row(5, 1'b1, 2, 1'b1, 1'b0);
  endtask

  task automatic run_row(input int row);
    int                     n;
    int                     errs_before;
    logic                   exp_overrun;
    logic [`ADDR_WIDTH-1:0] addr;
    loader_pkg::word_t      w;
    loader_pkg::word_t      got;
    errs_before = err_count;
    n = tbl_prog[row] ? tbl_words[row] : 0;
    // finished loader never pops, so extra bytes pile up in the FIFO
    exp_overrun = tbl_extra[row] && (EXTRA_WORDS * 2 > `RX_FIFO_DEPTH);
    apply_reset(tbl_prog[row]);
    check_value("done after reset", done, !tbl_prog[row]);
    if (tbl_prog[row]) begin
      if (tbl_bad[row]) begin
        send_frame(8'h5a, 1'b0);
      end
      for (int i = 0; i < n; i++) begin
        pick_word(w);
        sent[i] = w;
        send_word(w);
      end
      send_word(`LOAD_END_WORD);
    end
    wait_done(row);
    if (tbl_extra[row]) begin
      for (int i = 0; i < EXTRA_WORDS; i++) begin
        pick_word(w);
        send_word(w);
      end
      repeat (4) begin
        @(posedge rst);
        #10;
      end
    end
    check_value("done", done, 1'b1);
    check_value("word_count", word_count, n);
    check_value("rx_error", rx_error, tbl_bad[row]);
    check_value("overrun", overrun, exp_overrun);
    for (int i = 0; i < n; i++) begin
      addr = `ADDR_WIDTH'(`LOAD_BASE + 2 * i);
      read_word(addr, got);
      check_value($sformatf("word %0d high byte", i), got[15:8], sent[i][15:8]);
      check_value($sformatf("word %0d low byte", i), got[7:0], sent[i][7:0]);
    end
    // slot after the last word keeps its older contents
    if (tbl_prog[row] && model_known[n]) begin
      addr = `ADDR_WIDTH'(`LOAD_BASE + 2 * n);
      read_word(addr, got);
      check_value("slot after terminator", got, model_word[n]);
    end
    for (int i = 0; i < n; i++) begin
      model_word[i]  = sent[i];
      model_known[i] = 1'b1;
    end
    if (err_count == errs_before) begin
      pass_count++;
      $display("row %0d: rx_prog=%0b words=%0d bad_frame=%0b extra=%0b passed",
               row, tbl_prog[row], n, tbl_bad[row], tbl_extra[row]);
    end else begin
      fail_count++;
      $display("row %0d: rx_prog=%0b words=%0d bad_frame=%0b extra=%0b failed",
               row, tbl_prog[row], n, tbl_bad[row], tbl_extra[row]);
    end
  endtask

  initial begin
    rst        = 1'b0;
    clk        = 1'b1;
    uart_rx    = 1'b1;
    rx_prog    = 1'b0;
    rd_addr    = '0;
    lcg_state  = 32'h77de;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model_known[i] = 1'b0;
      model_word[i]  = '0;
    end
    fill_table();
    @(posedge rst);
    #10;
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    $display("%0d rows passed, %0d rows failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/loader_pkg.sv
source/uart_rx.sv
source/rx_fifo.sv
source/word_loader.sv
source/prog_ram.sv
source/prog_loader.sv
bench/prog_loader_tb.sv

//--- source/loader_config.svh
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// byte address width of program memory
`define ADDR_WIDTH 12

// first byte address written by the loader
`define LOAD_BASE 'h300

// word that ends a program, never stored
`define LOAD_END_WORD 16'h7fff

// bytes buffered between receiver and loader
`define RX_FIFO_DEPTH 4

// clock cycles per serial bit
`define CLKS_PER_BIT 16

`endif

//--- source/loader_pkg.sv
`default_nettype none

package loader_pkg;

  // one byte as it comes off the serial line
  typedef logic [7:0] byte_t;

  // one program word, high byte received first
  typedef logic [15:0] word_t;

  // loader phase
  // wait_high and wait_low alternate while a program streams in
  typedef enum logic [1:0] {
    wait_high = 2'd0,
    wait_low  = 2'd1,
    finished  = 2'd2
  } load_state_e;

endpackage

`default_nettype wire

//--- source/prog_loader.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module prog_loader (
  input  logic                   rst,
  input  logic                   clk,
  input  logic                   uart_rx,
  input  logic                   rx_prog,
  input  logic [`ADDR_WIDTH-1:0] rd_addr,
  output loader_pkg::word_t      rd_data,
  output logic                   done,
  output logic [`ADDR_WIDTH-1:0] word_count,
  output logic                   rx_error,
  output logic                   overrun
);

  logic                   byte_valid;
  loader_pkg::byte_t      byte_data;
  logic                   fifo_empty;
  loader_pkg::byte_t      fifo_head;
  logic                   fifo_pop;
  logic                   wr_en;
  logic [`ADDR_WIDTH-1:0] wr_addr;
  loader_pkg::word_t      wr_data;

  // serial line to bytes
  uart_rx u_uart_rx (
    .rst        (rst),
    .clk        (clk),
    .rx         (uart_rx),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .rx_error   (rx_error)
  );

  rx_fifo u_rx_fifo (
    .rst       (rst),
    .clk       (clk),
    .push      (byte_valid),
    .push_data (byte_data),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .overrun   (overrun)
  );

  // bytes to words, words to memory
  word_loader u_word_loader (
    .rst        (rst),
    .clk        (clk),
    .rx_prog    (rx_prog),
    .empty      (fifo_empty),
    .head       (fifo_head),
    .pop        (fifo_pop),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .done       (done),
    .word_count (word_count)
  );

  prog_ram u_prog_ram (
    .rst     (rst),
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- source/prog_ram.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module prog_ram (
  input  logic                   rst,
  input  logic                   clk,
  input  logic                   wr_en,
  input  logic [`ADDR_WIDTH-1:0] wr_addr,
  input  loader_pkg::word_t      wr_data,
  input  logic [`ADDR_WIDTH-1:0] rd_addr,
  output loader_pkg::word_t      rd_data
);

  localparam int WORDS = 2 ** (`ADDR_WIDTH - 1);

  // word storage indexed by byte address without bit 0
  loader_pkg::word_t mem [WORDS];

  always_ff @(posedge rst) begin
    if (wr_en) begin
      mem[wr_addr[`ADDR_WIDTH-1:1]] <= wr_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr[`ADDR_WIDTH-1:1]];
    end
  end

endmodule

`default_nettype wire

//--- source/rx_fifo.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
  parameter int DEPTH = `RX_FIFO_DEPTH
) (
  input  logic              rst,
  input  logic              clk,
  input  logic              push,
  input  loader_pkg::byte_t push_data,
  input  logic              pop,
  output loader_pkg::byte_t head,
  output logic              empty,
  output logic              overrun
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  loader_pkg::byte_t mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign full    = (count == FULL_CNT);
  assign empty   = (count == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // oldest entry shown ahead of the pop
  assign head = mem[rd_ptr];

  always_ff @(posedge rst) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky, no back-pressure toward the line
      if (push && full) begin
        overrun <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
  input  logic              rst,
  input  logic              clk,
  input  logic              rx,
  output logic              byte_valid,
  output loader_pkg::byte_t byte_data,
  output logic              rx_error
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              start_edge;
  logic [1:0]        state;
  logic [CNT_W-1:0]  tick_cnt;
  logic [2:0]        bit_idx;
  loader_pkg::byte_t shift;

  // two flops against metastability, a third for the edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;

  // shift register holds the last complete byte until the next frame
  assign byte_data = shift;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state      <= ST_IDLE;
      tick_cnt   <= '0;
      bit_idx    <= '0;
      shift      <= '0;
      byte_valid <= 1'b0;
      rx_error   <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          tick_cnt <= '0;
          if (start_edge) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          if (tick_cnt == HALF_BIT) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            // line back high at mid start bit, just a glitch
            state    <= rx_sync ? ST_IDLE : ST_DATA;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (tick_cnt == FULL_BIT) begin
            tick_cnt <= '0;
            // lsb first
            shift    <= {rx_sync, shift[7:1]};
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= ST_STOP;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (tick_cnt == FULL_BIT) begin
            tick_cnt <= '0;
            state    <= ST_IDLE;
            if (rx_sync) begin
              byte_valid <= 1'b1;
            end else begin
              // framing error, byte is dropped
              rx_error <= 1'b1;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/word_loader.sv
`include "loader_config.svh"
`timescale 1ns/1ps
`default_nettype none

module word_loader (
  input  logic                   rst,
  input  logic                   clk,
  input  logic                   rx_prog,
  input  logic                   empty,
  input  loader_pkg::byte_t      head,
  output logic                   pop,
  output logic                   wr_en,
  output logic [`ADDR_WIDTH-1:0] wr_addr,
  output loader_pkg::word_t      wr_data,
  output logic                   done,
  output logic [`ADDR_WIDTH-1:0] word_count
);

  localparam logic [`ADDR_WIDTH-1:0] BASE_ADDR = `ADDR_WIDTH'(`LOAD_BASE);
  localparam loader_pkg::word_t      END_WORD  = `LOAD_END_WORD;

  loader_pkg::load_state_e state;
  loader_pkg::byte_t       high_byte;
  loader_pkg::word_t       next_word;

  // take every byte on offer until the terminator is seen
  assign pop  = ~empty & (state != loader_pkg::finished);
  assign done = (state == loader_pkg::finished);

  // word completed by the byte at the head
  assign next_word = {high_byte, head};

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      // rx_prog low skips loading entirely
      if (rx_prog) begin
        state <= loader_pkg::wait_high;
      end else begin
        state <= loader_pkg::finished;
      end
      high_byte <= '0;
      wr_en     <= 1'b0;
      wr_data   <= '0;
    end else begin
      wr_en <= 1'b0;
      if (pop) begin
        case (state)
          loader_pkg::wait_high: begin
            high_byte <= head;
            state     <= loader_pkg::wait_low;
          end
          loader_pkg::wait_low: begin
            if (next_word == END_WORD) begin
              // terminator, nothing written
              state <= loader_pkg::finished;
            end else begin
              wr_en   <= 1'b1;
              wr_data <= next_word;
              state   <= loader_pkg::wait_high;
            end
          end
          default: begin
            state <= loader_pkg::finished;
          end
        endcase
      end
    end
  end

  // address moves on once the current word has been written
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      wr_addr    <= BASE_ADDR;
      word_count <= '0;
    end else if (wr_en) begin
      wr_addr    <= wr_addr + `ADDR_WIDTH'd2;
      word_count <= word_count + 1'b1;
    end
  end

endmodule

`default_nettype wire
